// ==== hdl/cpu_types_pkg.sv ====
// cpu types
// shared encodings, select codes and stage latch layouts for the
// five-stage MIPS subset core
package cpu_types_pkg;

  // memory geometry in words
  localparam int MEM_WORDS = 256;
  localparam int ADDR_W    = 8;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcodes, all-ones is halt
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00, OP_J    = 6'h02, OP_JAL  = 6'h03, OP_BEQ  = 6'h04,
    OP_BNE   = 6'h05, OP_ADDIU = 6'h09, OP_ORI = 6'h0d, OP_LUI  = 6'h0f,
    OP_LW    = 6'h23, OP_SW    = 6'h2b, OP_HALT = 6'h3f
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    FN_SLL = 6'h00, FN_JR = 6'h08, FN_ADDU = 6'h21, FN_SUBU = 6'h23,
    FN_AND = 6'h24, FN_OR = 6'h25, FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL
  } aluop_t;

  typedef enum logic [1:0] {SRC_REG, SRC_SHAMT, SRC_IMM} alusrc_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LUI, WB_RA} wbsel_t;
  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JR} pcsrc_t;
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_t;

  // decode controls, 17 bits
  typedef struct packed {
    aluop_t   aluop;
    alusrc_t  alusrc;
    wbsel_t   wbsel;
    logic     reg_wen;
    regbits_t wsel;
    logic     mem_ren;
    logic     mem_wen;
    logic     bne;
    logic     halt;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t npc;
  } if_id_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    pcsrc_t      pcsrc;
    word_t       npc;
    word_t       rdat1;
    word_t       rdat2;
    word_t       ext;
    logic [4:0]  shamt;
    logic [25:0] jaddr;
    regbits_t    rs;
    regbits_t    rt;
  } id_ex_t;

  // result already holds alu, lui or return address
  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t result;
    word_t wdata;
  } ex_mem_t;

  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t result;
    word_t load;
  } mem_wb_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

// ==== hdl/control_unit.sv ====
// control unit
// decodes one instruction word into the decode-stage controls
module control_unit (
  input  cpu_types_pkg::word_t    instr,
  output cpu_types_pkg::ctrl_t    ctrl,
  output cpu_types_pkg::regbits_t rs,
  output cpu_types_pkg::regbits_t rt,
  output logic [15:0]             imm16,
  output logic [4:0]              shamt,
  output logic [25:0]             jaddr,
  output cpu_types_pkg::pcsrc_t   pcsrc,
  output logic                    sign_ext
);
  import cpu_types_pkg::*;

  opcode_t  op;
  funct_t   fn;
  regbits_t rd;

  // raw fields
  assign op    = opcode_t'(instr[31:26]);
  assign fn    = funct_t'(instr[5:0]);
  assign rd    = instr[15:11];
  assign rt    = instr[20:16];
  assign imm16 = instr[15:0];
  assign shamt = instr[10:6];
  assign jaddr = instr[25:0];

  always_comb
  begin
    // everything off is a nop
    ctrl     = '0;
    pcsrc    = PC_PLUS4;
    sign_ext = 1'b0;
    rs       = instr[25:21];
    case (op)
      OP_RTYPE:
      begin
        ctrl.wsel    = rd;
        ctrl.reg_wen = 1'b1;
        case (fn)
          FN_ADDU: ctrl.aluop = ALU_ADD;
          FN_SUBU: ctrl.aluop = ALU_SUB;
          FN_AND:  ctrl.aluop = ALU_AND;
          FN_OR:   ctrl.aluop = ALU_OR;
          FN_SLT:  ctrl.aluop = ALU_SLT;
          FN_SLL:
          begin
            // shift source on the a side, so rt is read through the rs port
            ctrl.aluop  = ALU_SLL;
            ctrl.alusrc = SRC_SHAMT;
            rs          = instr[20:16];
          end
          FN_JR:
          begin
            ctrl.reg_wen = 1'b0;
            pcsrc        = PC_JR;
          end
          default: ctrl.reg_wen = 1'b0;
        endcase
      end
      OP_ADDIU, OP_LW, OP_SW:
      begin
        ctrl.alusrc  = SRC_IMM;
        sign_ext     = 1'b1;
        ctrl.wsel    = rt;
        ctrl.reg_wen = (op != OP_SW);
        ctrl.mem_ren = (op == OP_LW);
        ctrl.mem_wen = (op == OP_SW);
        ctrl.wbsel   = (op == OP_LW) ? WB_LOAD : WB_ALU;
      end
      OP_ORI:
      begin
        ctrl.aluop   = ALU_OR;
        ctrl.alusrc  = SRC_IMM;
        ctrl.wsel    = rt;
        ctrl.reg_wen = 1'b1;
      end
      OP_LUI:
      begin
        ctrl.wbsel   = WB_LUI;
        ctrl.wsel    = rt;
        ctrl.reg_wen = 1'b1;
      end
      OP_BEQ, OP_BNE:
      begin
        // compare by subtract, offset sign extended
        ctrl.aluop = ALU_SUB;
        ctrl.bne   = (op == OP_BNE);
        sign_ext   = 1'b1;
        pcsrc      = PC_BRANCH;
      end
      OP_J: pcsrc = PC_JUMP;
      OP_JAL:
      begin
        pcsrc        = PC_JUMP;
        ctrl.wbsel   = WB_RA;
        ctrl.wsel    = 5'd31;
        ctrl.reg_wen = 1'b1;
      end
      OP_HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== hdl/register_file.sv ====
// register file
// 31 writable registers plus a hardwired zero, write data bypassed to reads
module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [1:31];
  logic  wr_live;

  // writes to r0 dropped here
  assign wr_live = wen && (wsel != '0);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      regs <= '{default: '0};
    else if (wr_live)
      regs[wsel] <= wdat;
  end

  // same-cycle write shows up on the read side
  assign rdat1 = (rsel1 == '0) ? '0 : (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// ==== hdl/alu.sv ====
// alu
// add, sub, and, or, signed slt and shift left, with a zero flag
module alu (
  input  cpu_types_pkg::aluop_t op,
  input  cpu_types_pkg::word_t  a,
  input  cpu_types_pkg::word_t  b,
  output cpu_types_pkg::word_t  result,
  output logic                  zero
);
  import cpu_types_pkg::*;

  always_comb
  begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // signed compare
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      // shift amount from low bits only
      ALU_SLL: result = a << b[4:0];
      default: result = '0;
    endcase
  end

  // branch compare looks at this after a subtract
  assign zero = (result == '0);

endmodule

// ==== hdl/hazard_unit.sv ====
// hazard unit
// operand forwarding selects, load-use stall and control-transfer flush
module hazard_unit (
  input  cpu_types_pkg::id_ex_t   id_ex,
  input  cpu_types_pkg::ex_mem_t  ex_mem,
  input  cpu_types_pkg::mem_wb_t  mem_wb,
  input  cpu_types_pkg::regbits_t rs,
  input  cpu_types_pkg::regbits_t rt,
  input  logic                    take_branch,
  output cpu_types_pkg::fwd_t     fwd_a,
  output cpu_types_pkg::fwd_t     fwd_b,
  output logic                    stall,
  output logic                    flush
);
  import cpu_types_pkg::*;

  logic mem_wr;
  logic wb_wr;

  // producers that actually write a nonzero register
  assign mem_wr = ex_mem.valid && ex_mem.ctrl.reg_wen && (ex_mem.ctrl.wsel != '0);
  assign wb_wr  = mem_wb.valid && mem_wb.ctrl.reg_wen && (mem_wb.ctrl.wsel != '0);

  // younger producer wins
  function automatic fwd_t pick(regbits_t src, logic m_wr, regbits_t m_sel,
                                logic w_wr, regbits_t w_sel);
    if (m_wr && m_sel == src)
      return FWD_MEM;
    else if (w_wr && w_sel == src)
      return FWD_WB;
    return FWD_REG;
  endfunction

  assign fwd_a = pick(id_ex.rs, mem_wr, ex_mem.ctrl.wsel, wb_wr, mem_wb.ctrl.wsel);
  assign fwd_b = pick(id_ex.rt, mem_wr, ex_mem.ctrl.wsel, wb_wr, mem_wb.ctrl.wsel);

  // load in execute feeding decode, one bubble
  assign stall = id_ex.valid && id_ex.ctrl.mem_ren && (id_ex.ctrl.wsel != '0) &&
                 (id_ex.ctrl.wsel == rs || id_ex.ctrl.wsel == rt);

  // jumps always, branches when taken
  // halt also drains the two younger slots
  assign flush = take_branch ||
                 (id_ex.valid && (id_ex.pcsrc == PC_JUMP || id_ex.pcsrc == PC_JR ||
                                  id_ex.ctrl.halt));

endmodule

// ==== hdl/datapath.sv ====
// datapath
// five-stage pipeline with pc, stage latches, forwarding and the
// memory request path
module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     run,
  output cpu_types_pkg::word_t     imem_addr,
  input  cpu_types_pkg::word_t     imem_data,
  input  logic                     ihit,
  output cpu_types_pkg::dmem_req_t dreq,
  input  cpu_types_pkg::word_t     dload,
  input  logic                     dhit,
  output logic                     halt
);
  import cpu_types_pkg::*;

  word_t   pc, npc, redirect;
  if_id_t  if_id;
  id_ex_t  id_ex, id_ex_next;
  ex_mem_t ex_mem, ex_mem_next;
  mem_wb_t mem_wb, mem_wb_next;

  // decode side
  ctrl_t       dec_ctrl;
  regbits_t    dec_rs, dec_rt;
  logic [15:0] dec_imm16;
  logic [4:0]  dec_shamt;
  logic [25:0] dec_jaddr;
  pcsrc_t      dec_pcsrc;
  logic        dec_sign_ext;
  word_t       rdat1, rdat2;

  // execute side
  fwd_t  fwd_a, fwd_b;
  word_t op_a, rt_val, op_b, alu_out, ex_result;
  logic  alu_zero, take_branch, stall, flush;

  logic  mem_wait, advance;
  word_t wb_data;

  control_unit cu (
    .instr(if_id.instr), .ctrl(dec_ctrl), .rs(dec_rs), .rt(dec_rt),
    .imm16(dec_imm16), .shamt(dec_shamt), .jaddr(dec_jaddr),
    .pcsrc(dec_pcsrc), .sign_ext(dec_sign_ext)
  );

  register_file rf (
    .CLK, .nRST,
    .wen(mem_wb.valid && mem_wb.ctrl.reg_wen), .wsel(mem_wb.ctrl.wsel),
    .rsel1(dec_rs), .rsel2(dec_rt), .wdat(wb_data),
    .rdat1, .rdat2
  );

  alu alu_i (.op(id_ex.ctrl.aluop), .a(op_a), .b(op_b), .result(alu_out), .zero(alu_zero));

  hazard_unit hu (
    .id_ex, .ex_mem, .mem_wb, .rs(dec_rs), .rt(dec_rt), .take_branch,
    .fwd_a, .fwd_b, .stall, .flush
  );

  // whole pipe moves together
  // frozen before run, after halt and while a data access waits
  assign mem_wait = ex_mem.valid && (ex_mem.ctrl.mem_ren || ex_mem.ctrl.mem_wen) && !dhit;
  assign advance  = run && ihit && !mem_wait && !halt;

  // fetch
  assign imem_addr = pc;
  assign npc       = pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc    <= PC_INIT;
      if_id <= '0;
    end
    else if (advance)
    begin
      if (flush)
      begin
        pc    <= redirect;
        if_id <= '0;
      end
      else if (!stall)
      begin
        pc          <= npc;
        if_id.valid <= 1'b1;
        if_id.instr <= imem_data;
        if_id.npc   <= npc;
      end
    end
  end

  // decode, bubble on stall or flush
  always_comb
  begin
    id_ex_next       = '0;
    id_ex_next.valid = if_id.valid && !stall && !flush;
    id_ex_next.ctrl  = dec_ctrl;
    id_ex_next.pcsrc = dec_pcsrc;
    id_ex_next.npc   = if_id.npc;
    id_ex_next.rdat1 = rdat1;
    id_ex_next.rdat2 = rdat2;
    id_ex_next.ext   = dec_sign_ext ? {{16{dec_imm16[15]}}, dec_imm16} : {16'b0, dec_imm16};
    id_ex_next.shamt = dec_shamt;
    id_ex_next.jaddr = dec_jaddr;
    id_ex_next.rs    = dec_rs;
    id_ex_next.rt    = dec_rt;
  end

  // execute operands through the forward muxes
  always_comb
  begin
    case (fwd_a)
      FWD_MEM: op_a = ex_mem.result;
      FWD_WB:  op_a = wb_data;
      default: op_a = id_ex.rdat1;
    endcase
    case (fwd_b)
      FWD_MEM: rt_val = ex_mem.result;
      FWD_WB:  rt_val = wb_data;
      default: rt_val = id_ex.rdat2;
    endcase
    case (id_ex.ctrl.alusrc)
      SRC_SHAMT: op_b = {27'b0, id_ex.shamt};
      SRC_IMM:   op_b = id_ex.ext;
      default:   op_b = rt_val;
    endcase
  end

  // non-load writeback value picked here
  always_comb
  begin
    case (id_ex.ctrl.wbsel)
      WB_LUI:  ex_result = {id_ex.ext[15:0], 16'b0};
      WB_RA:   ex_result = id_ex.npc;
      default: ex_result = alu_out;
    endcase
  end

  // beq on zero, bne on nonzero
  assign take_branch = id_ex.valid && (id_ex.pcsrc == PC_BRANCH) &&
                       (alu_zero ^ id_ex.ctrl.bne);

  // halt holds the pc where it is
  always_comb
  begin
    case (id_ex.pcsrc)
      PC_BRANCH: redirect = id_ex.npc + {id_ex.ext[29:0], 2'b00};
      PC_JUMP:   redirect = {id_ex.npc[31:28], id_ex.jaddr, 2'b00};
      PC_JR:     redirect = op_a;
      default:   redirect = pc;
    endcase
  end

  assign ex_mem_next = '{valid: id_ex.valid, ctrl: id_ex.ctrl,
                         result: ex_result, wdata: rt_val};

  // memory stage request, held by the freeze until dhit
  assign dreq.ren   = ex_mem.valid && ex_mem.ctrl.mem_ren;
  assign dreq.wen   = ex_mem.valid && ex_mem.ctrl.mem_wen;
  assign dreq.addr  = ex_mem.result;
  assign dreq.wdata = ex_mem.wdata;

  assign mem_wb_next = '{valid: ex_mem.valid, ctrl: ex_mem.ctrl,
                         result: ex_mem.result, load: dload};

  // writeback
  assign wb_data = (mem_wb.ctrl.wbsel == WB_LOAD) ? mem_wb.load : mem_wb.result;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end
    else if (advance)
    begin
      id_ex  <= id_ex_next;
      ex_mem <= ex_mem_next;
      mem_wb <= mem_wb_next;
    end
  end

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt <= 1'b0;
    else if (ex_mem.valid && ex_mem.ctrl.halt)
      halt <= 1'b1;
  end

endmodule

// ==== hdl/memory_model.sv ====
// memory model
// unified word memory, instruction port hits at once, data port
// answers one cycle after a request, plus a testbench load/dump port
module memory_model (
  input  logic                                CLK,
  input  logic                                nRST,
  input  cpu_types_pkg::word_t                iaddr,
  output cpu_types_pkg::word_t                idata,
  output logic                                ihit,
  input  cpu_types_pkg::dmem_req_t            dreq,
  output cpu_types_pkg::word_t                dload,
  output logic                                dhit,
  input  logic                                load_en,
  input  logic [cpu_types_pkg::ADDR_W-1:0]    load_addr,
  input  cpu_types_pkg::word_t                load_data,
  input  logic [cpu_types_pkg::ADDR_W-1:0]    dump_addr,
  output cpu_types_pkg::word_t                dump_data
);
  import cpu_types_pkg::*;

  word_t              mem [MEM_WORDS];
  logic               waited;
  logic               dreq_live;
  logic [ADDR_W-1:0]  dword;

  // word index from byte address
  assign dword     = dreq.addr[ADDR_W+1:2];
  assign dreq_live = dreq.ren || dreq.wen;

  // instruction side busy only while the loader writes
  assign idata = mem[iaddr[ADDR_W+1:2]];
  assign ihit  = !load_en;

  // one wait cycle then hit, flag drops after the hit
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      waited <= 1'b0;
    else
      waited <= dreq_live && !dhit;
  end

  assign dhit  = dreq_live && waited;
  assign dload = mem[dword];

  // loader first, then store on its hit cycle
  always_ff @(posedge CLK)
  begin
    if (load_en)
      mem[load_addr] <= load_data;
    else if (dreq.wen && dhit)
      mem[dword] <= dreq.wdata;
  end

  assign dump_data = mem[dump_addr];

endmodule

// ==== hdl/cpu_top.sv ====
// cpu top
// pipelined core wired to the unified memory model
module cpu_top (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             run,
  input  logic                             load_en,
  input  logic [cpu_types_pkg::ADDR_W-1:0] load_addr,
  input  cpu_types_pkg::word_t             load_data,
  input  logic [cpu_types_pkg::ADDR_W-1:0] dump_addr,
  output cpu_types_pkg::word_t             dump_data,
  output logic                             halt
);
  import cpu_types_pkg::*;

  // core to memory
  word_t     imem_addr, imem_data, dload;
  logic      ihit, dhit;
  dmem_req_t dreq;

  datapath core (
    .CLK, .nRST, .run, .imem_addr, .imem_data, .ihit,
    .dreq, .dload, .dhit, .halt
  );

  memory_model mem (
    .CLK, .nRST, .iaddr(imem_addr), .idata(imem_data), .ihit,
    .dreq, .dload, .dhit, .load_en, .load_addr, .load_data,
    .dump_addr, .dump_data
  );

endmodule

// ==== dv/cpu_chk.sv ====
// cpu checker
// memory handshake and halt properties on the datapath, bound in
module cpu_chk (
  input logic                     CLK,
  input logic                     nRST,
  input cpu_types_pkg::word_t     imem_addr,
  input cpu_types_pkg::dmem_req_t dreq,
  input logic                     dhit,
  input logic                     halt
);
  timeunit 1ns;
  timeprecision 1ps;

  // one kind of access at a time
  a_one_kind: assert property (@(posedge CLK) disable iff (!nRST)
    !(dreq.ren && dreq.wen))
    else $error("read and write request high together");

  // request held until the memory answers
  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dreq.ren || dreq.wen) && !dhit |=> $stable(dreq))
    else $error("data request changed before dhit");

  // sticky halt, fetch frozen behind it
  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt && $stable(imem_addr))
    else $error("halt dropped or fetch moved while halted");

  a_no_store_halted: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !dreq.wen)
    else $error("store request while halted");

endmodule

bind datapath cpu_chk chk (.CLK, .nRST, .imem_addr, .dreq, .dhit, .halt);

// ==== dv/tb_cpu.sv ====
// cpu testbench
// loads each program from the data file, runs it to halt and
// compares the expected memory words through the dump port
module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_types_pkg::*;

  localparam int MAX_CYCLES = 400;
  localparam int PERIOD     = 40;

  logic              CLK;
  logic              nRST;
  logic              run;
  logic              load_en;
  logic [ADDR_W-1:0] load_addr;
  word_t             load_data;
  logic [ADDR_W-1:0] dump_addr;
  word_t             dump_data;
  logic              halt;

  // parsed test data
  string names[$];
  int    p_test[$];
  int    p_addr[$];
  word_t p_data[$];
  int    e_test[$];
  int    e_addr[$];
  word_t e_data[$];
  logic  parsed;
  int    errors;
  int    checks;

  cpu_top dut (
    .CLK, .nRST, .run, .load_en, .load_addr, .load_data,
    .dump_addr, .dump_data, .halt
  );

  initial
  begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // step to the drive point after the next rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic reset_core();
    nRST    = 1'b0;
    run     = 1'b0;
    load_en = 1'b0;
    repeat (3) next_cycle();
    nRST = 1'b1;
  endtask

  // program words go in with random gaps
  task automatic load_program(input int t);
    int gap;
    for (int i = 0; i < p_test.size(); i++)
    begin
      if (p_test[i] == t)
      begin
        load_en   = 1'b1;
        load_addr = p_addr[i][ADDR_W-1:0];
        load_data = p_data[i];
        next_cycle();
        load_en = 1'b0;
        gap     = $urandom % 3;
        repeat (gap) next_cycle();
      end
    end
  endtask

  task automatic read_file();
    int    fd;
    int    code;
    int    a;
    word_t d;
    string tok;
    string line;
    fd = $fopen("dv/cpu_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open dv/cpu_testdata.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1)
          break;
        if (tok == "#")
          code = $fgets(line, fd);
        else if (tok == "T")
        begin
          code = $fscanf(fd, "%s", tok);
          names.push_back(tok);
        end
        else if (tok == "P" || tok == "E")
        begin
          code = $fscanf(fd, "%h %h", a, d);
          if (tok == "P")
          begin
            p_test.push_back(names.size() - 1);
            p_addr.push_back(a);
            p_data.push_back(d);
          end
          else
          begin
            e_test.push_back(names.size() - 1);
            e_addr.push_back(a);
            e_data.push_back(d);
          end
        end
      end
      $fclose(fd);
      if (names.size() == 0)
      begin
        $display("no tests found in dv/cpu_testdata.txt");
        errors++;
      end
    end
  endtask

  task automatic run_test(input int t);
    int  cyc;
    int  fails;
    bit  done;
    fails = 0;
    reset_core();
    load_program(t);
    run  = 1'b1;
    cyc  = 0;
    done = 1'b0;
    // halt sampled at the drive point, clear of the edge
    while (!done && cyc < MAX_CYCLES)
    begin
      next_cycle();
      done = halt;
      cyc++;
    end
    assert (done)
    else
    begin
      $display("test %s did not reach halt within %0d cycles", names[t], MAX_CYCLES);
      fails++;
    end
    for (int i = 0; i < e_test.size(); i++)
    begin
      if (e_test[i] == t)
      begin
        dump_addr = e_addr[i][ADDR_W-1:0];
        #1;
        checks++;
        assert (dump_data === e_data[i])
        else
        begin
          $display("ERR dump_data addr %h exp %h got %h", dump_addr, e_data[i], dump_data);
          fails++;
        end
      end
    end
    errors += fails;
    $display("test %-10s %s after %0d cycles, %0d failing checks",
             names[t], (fails == 0) ? "ok" : "FAILED", cyc, fails);
  endtask

  // watchdog sized from the number of tests
  initial
  begin
    int limit;
    wait (parsed === 1'b1);
    limit = names.size() * MAX_CYCLES * PERIOD + 100 * PERIOD;
    #(limit);
    $display("watchdog expired, simulation stopped before all tests ended");
    $display("Errors found");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h1810));
    nRST      = 1'b0;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    dump_addr = '0;
    errors    = 0;
    checks    = 0;
    parsed    = 1'b0;
    read_file();
    parsed = 1'b1;
    for (int t = 0; t < names.size(); t++)
      run_test(t);
    $display("tests %0d, checks %0d, errors %0d", names.size(), checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== dv/cpu_testdata.txt ====
# T name, P word_addr instr_or_data (hex), E word_addr expected (hex)
# programs start at word 0, each test keeps its own data words
T alu_fwd
P 00 24010005
P 01 24020003
P 02 00221821
P 03 00612023
P 04 00812824
P 05 00A33025
P 06 0046382A
P 07 AC070110
P 08 AC030100
P 09 AC040104
P 0A AC050108
P 0B AC06010C
P 0C FC000000
E 40 00000008
E 41 00000003
E 42 00000001
E 43 00000009
E 44 00000001
T load_use
P 50 0000000B
P 51 00000020
P 00 8C010140
P 01 8C020144
P 02 00221821
P 03 AC030148
P 04 8C040148
P 05 00842821
P 06 AC05014C
P 07 FC000000
E 52 0000002B
E 53 00000056
T branch
P 60 DEAD0060
P 61 DEAD0061
P 62 DEAD0062
P 63 DEAD0063
P 64 DEAD0064
P 00 24010001
P 01 24020001
P 02 10220002
P 03 AC010180
P 04 AC010184
P 05 14220001
P 06 AC020188
P 07 10200001
P 08 24030007
P 09 14600001
P 0A AC03018C
P 0B AC030190
P 0C FC000000
E 60 DEAD0060
E 61 DEAD0061
E 62 00000001
E 63 DEAD0063
E 64 00000007
T jumps
P 72 DEAD0072
P 00 0C000004
P 01 AC0201C4
P 02 08000007
P 03 AC0201C8
P 04 AC1F01C0
P 05 24020055
P 06 03E00008
P 07 FC000000
E 70 00000004
E 71 00000055
E 72 DEAD0072
T constants
P 83 DEAD0083
P 00 3C011234
P 01 34215678
P 02 2402FFFE
P 03 00011900
P 04 24000009
P 05 00022021
P 06 AC010200
P 07 AC020204
P 08 AC030208
P 09 AC00020C
P 0A AC040210
P 0B 0040282A
P 0C AC050214
P 0D FC000000
E 80 12345678
E 81 FFFFFFFE
E 82 23456780
E 83 00000000
E 84 FFFFFFFE
E 85 00000001

// ==== tb.f ====
hdl/cpu_types_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/datapath.sv
hdl/memory_model.sv
hdl/cpu_top.sv
dv/cpu_chk.sv
dv/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' tb.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) tb.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
